//--- x86_alu_core.f
x86_isa_pkg.sv
x86_exec_pkg.sv
insn_decode.sv
register_file.sv
alu_execute.sv
result_queue.sv
x86_alu_core.sv
x86_alu_core_assertions.sv
tb_x86_alu_core.sv

//--- Makefile
# Verilator build and run for the x86_alu_core testbench

TOP := tb_x86_alu_core

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): x86_alu_core.f $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f x86_alu_core.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb_x86_alu_core.sv
// Table-driven testbench for x86_alu_core with a reference model.
// Expected results are computed before the run, then the table is applied in order.
// out_ready toggles at random; handshakes are sampled on the falling clock edge.

`timescale 1ns/1ps

module tb_x86_alu_core;
    import x86_isa_pkg::*;
    import x86_exec_pkg::*;

    localparam int          tb_timeout = 200;
    localparam int          n_tests    = 24;
    localparam logic [31:0] seed       = 32'h6ac1c496;

    // Register forms use ModRM 11 src dst
    localparam logic [15:0] insn_tab [n_tests] = '{
        16'hb012, 16'hb434, 16'hb1f0, 16'hb5ff,   // MOV AL, AH, CL, CH
        16'hb201, 16'hb680, 16'hb300, 16'hb77f,   // MOV DL, DH, BL, BH
        16'h01c8, 16'h01db, 16'h01f2, 16'h29c1,   // ADD AX,CX  ADD BX,BX  ADD DX,SI  SUB CX,AX
        16'h29d8, 16'h08e8, 16'h20cc, 16'h30fb,   // SUB AX,BX  OR AL,CH  AND AH,CL  XOR BL,BH
        16'h09f0, 16'h39c1, 16'h01f1, 16'h29d2,   // OR AX,SI  CMP CX,AX  ADD CX,SI  SUB DX,DX
        16'h0100, 16'h2947, 16'h0fc0, 16'h01e3    // two memory forms, bad opcode, ADD BX,SP
    };

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid;
    logic [insn_w-1:0]    in_insn;
    logic                 in_ready;
    logic                 out_valid;
    logic                 out_ready;
    logic [reg_idx_w-1:0] out_reg;
    logic [data_w-1:0]    out_value;
    logic [flags_w-1:0]   out_flags;
    logic                 out_illegal;

    logic [data_w-1:0]    ref_regs [8];
    logic [flags_w-1:0]   ref_flags;
    logic [reg_idx_w-1:0] exp_reg [n_tests];
    logic [data_w-1:0]    exp_value [n_tests];
    logic [flags_w-1:0]   exp_flags [n_tests];
    logic                 exp_illegal [n_tests];
    logic [31:0]          rng;
    logic                 extra;
    int                   pass_count;
    int                   fail_count;

    x86_alu_core x86_alu_core_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_insn    (in_insn),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_reg    (out_reg),
        .out_value  (out_value),
        .out_flags  (out_flags),
        .out_illegal(out_illegal)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Random back-pressure on the output channel
    always @(posedge clk) begin
        #2;
        rng       = xorshift(rng);
        out_ready = rng[0];
    end

    function automatic int read_reg(input logic [2:0] n, input logic byte_op);
        if (!byte_op) begin
            return int'(ref_regs[n]);
        end else if (n < 4) begin
            return int'(ref_regs[n][7:0]);
        end
        return int'(ref_regs[n - 4][15:8]);
    endfunction

    task automatic write_reg(input logic [2:0] n, input logic byte_op, input int v);
        if (!byte_op) begin
            ref_regs[n] = v[15:0];
        end else if (n < 4) begin
            ref_regs[n][7:0] = v[7:0];
        end else begin
            ref_regs[n - 4][15:8] = v[7:0];
        end
    endtask

    task automatic model_insn(input int i);
        logic [7:0]         opc;
        logic [7:0]         lo;
        logic               byte_op;
        logic               legal;
        logic [flags_w-1:0] f;
        int                 kind;
        int                 a;
        int                 b;
        int                 r;
        int                 mask;
        int                 top;
        opc = insn_tab[i][15:8];
        lo  = insn_tab[i][7:0];
        case (opc)
            op_add8, op_add16: kind = 0;
            op_or8, op_or16:   kind = 1;
            op_and8, op_and16: kind = 2;
            op_sub8, op_sub16: kind = 3;
            op_xor8, op_xor16: kind = 4;
            op_cmp8, op_cmp16: kind = 5;
            default:           kind = (opc[7:3] == 5'b10110) ? 6 : -1;
        endcase
        legal          = kind == 6 || (kind >= 0 && lo[7:6] == mod_reg);
        exp_reg[i]     = '0;
        exp_value[i]   = '0;
        exp_flags[i]   = ref_flags;
        exp_illegal[i] = !legal;
        if (kind == 6) begin
            // MOV leaves the flags alone
            write_reg(opc[2:0], 1'b1, int'(lo));
            exp_reg[i]   = opc[2:0];
            exp_value[i] = {8'h00, lo};
        end else if (legal) begin
            byte_op = !opc[0];
            mask    = byte_op ? 'hff : 'hffff;
            top     = byte_op ? 'h80 : 'h8000;
            a       = read_reg(lo[2:0], byte_op);
            b       = read_reg(lo[5:3], byte_op);
            f       = '0;
            case (kind)
                0: begin
                    r         = a + b;
                    f[cf_idx] = r > mask;
                    r         = r & mask;
                    f[of_idx] = ((a ^ r) & (b ^ r) & top) != 0;
                end
                1: r = a | b;
                2: r = a & b;
                4: r = a ^ b;
                default: begin
                    // SUB and CMP, CF is the borrow
                    f[cf_idx] = a < b;
                    r         = (a - b) & mask;
                    f[of_idx] = ((a ^ b) & (a ^ r) & top) != 0;
                end
            endcase
            f[zf_idx] = r == 0;
            f[sf_idx] = (r & top) != 0;
            f[pf_idx] = $countones(r[7:0]) % 2 == 0;
            ref_flags = f;
            if (kind != 5) begin
                write_reg(lo[2:0], byte_op, r);
            end
            exp_reg[i]   = lo[2:0];
            exp_value[i] = r[15:0];
            exp_flags[i] = f;
        end
    endtask

    task automatic send_all();
        int waited;
        for (int i = 0; i < n_tests; i++) begin
            in_valid = 1'b1;
            in_insn  = insn_tab[i];
            waited   = 0;
            @(negedge clk);
            while (!in_ready && waited < tb_timeout) begin
                @(negedge clk);
                waited++;
            end
            if (!in_ready) begin
                $display("Instruction %0d was never accepted by the DUT", i);
                fail_count++;
                break;
            end
            @(posedge clk);
            #2;
        end
        in_valid = 1'b0;
    endtask

    task automatic collect_results();
        int waited;
        int bad;
        for (int i = 0; i < n_tests; i++) begin
            waited = 0;
            @(negedge clk);
            while (!(out_valid && out_ready) && waited < tb_timeout) begin
                @(negedge clk);
                waited++;
            end
            if (!(out_valid && out_ready)) begin
                $display("Test %0d timed out waiting for a result", i);
                fail_count += n_tests - i;
                break;
            end
            bad = 0;
            if (out_reg !== exp_reg[i]) begin
                $display("Fail test %0d out_reg expected %h got %h", i, exp_reg[i], out_reg);
                bad++;
            end
            if (out_value !== exp_value[i]) begin
                $display("Fail test %0d out_value expected %h got %h", i, exp_value[i],
                         out_value);
                bad++;
            end
            if (out_flags !== exp_flags[i]) begin
                $display("Fail test %0d out_flags expected %h got %h", i, exp_flags[i],
                         out_flags);
                bad++;
            end
            if (out_illegal !== exp_illegal[i]) begin
                $display("Fail test %0d out_illegal expected %h got %h", i, exp_illegal[i],
                         out_illegal);
                bad++;
            end
            if (bad == 0) begin
                $display("Test %0d passed, insn %h", i, insn_tab[i]);
                pass_count++;
            end else begin
                fail_count++;
            end
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_insn    = '0;
        out_ready  = 1'b0;
        rng        = seed;
        extra      = 1'b0;
        pass_count = 0;
        fail_count = 0;
        ref_flags  = '0;
        for (int r = 0; r < 8; r++) begin
            ref_regs[r] = '0;
        end
        for (int i = 0; i < n_tests; i++) begin
            model_insn(i);
        end
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        fork
            send_all();
            collect_results();
        join
        // Nothing may follow the last result
        repeat (8) begin
            @(negedge clk);
            if (out_valid) begin
                extra = 1'b1;
            end
        end
        if (extra) begin
            $display("The DUT produced more results than instructions were sent");
            fail_count++;
        end
        $display("Tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- x86_alu_core_assertions.sv
// Concurrent checks on the output channel and decode stage of x86_alu_core.
// Bound into every x86_alu_core instance; dec_valid is an internal net there.

`timescale 1ns/1ps

module x86_alu_core_assertions (
    input logic                                clk,
    input logic                                rst_n,
    input logic                                in_ready,
    input logic                                dec_valid,
    input logic                                out_valid,
    input logic                                out_ready,
    input logic [x86_isa_pkg::reg_idx_w-1:0]   out_reg,
    input logic [x86_exec_pkg::data_w-1:0]     out_value,
    input logic [x86_exec_pkg::flags_w-1:0]    out_flags,
    input logic                                out_illegal
);

    // Queue is empty right after reset
    assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
        else $error("out_valid high in the cycle after reset release");

    // Payload holds while the consumer stalls
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid &&
            $stable({out_reg, out_value, out_flags, out_illegal}))
        else $error("output payload changed while stalled");

    // Input stalls only behind a held decode item and a pending result
    assert property (@(posedge clk) disable iff (!rst_n)
        !in_ready |-> dec_valid && out_valid)
        else $error("in_ready low without a held decode item and a pending result");

endmodule

bind x86_alu_core x86_alu_core_assertions x86_alu_core_assertions_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_ready   (in_ready),
    .dec_valid  (dec_valid),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_reg    (out_reg),
    .out_value  (out_value),
    .out_flags  (out_flags),
    .out_illegal(out_illegal)
);

//--- x86_alu_core.sv
// Register-form x86 ALU core: decode, execute and result queue in a row.
// Results leave in order, one cycle after acceptance when not back-pressured.
// At most three instructions are in flight.

`timescale 1ns/1ps

module x86_alu_core (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                in_valid,
    input  logic [x86_isa_pkg::insn_w-1:0]      in_insn,
    output logic                                in_ready,
    output logic                                out_valid,
    input  logic                                out_ready,
    output logic [x86_isa_pkg::reg_idx_w-1:0]   out_reg,
    output logic [x86_exec_pkg::data_w-1:0]     out_value,
    output logic [x86_exec_pkg::flags_w-1:0]    out_flags,
    output logic                                out_illegal
);
    import x86_isa_pkg::*;
    import x86_exec_pkg::*;

    logic                 dec_valid;
    logic                 dec_ready;
    logic [alu_op_w-1:0]  dec_op;
    logic                 dec_byte;
    logic [reg_idx_w-1:0] dec_dst;
    logic [reg_idx_w-1:0] dec_src;
    logic                 dec_use_imm;
    logic [7:0]           dec_imm;
    logic                 dec_write;
    logic                 dec_flags_wr;
    logic                 dec_illegal;

    logic                 q_full;
    logic                 q_push;
    logic [reg_idx_w-1:0] q_reg;
    logic [data_w-1:0]    q_value;
    logic [flags_w-1:0]   q_flags;
    logic                 q_illegal;

    insn_decode insn_decode_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_insn     (in_insn),
        .in_ready    (in_ready),
        .dec_valid   (dec_valid),
        .dec_ready   (dec_ready),
        .dec_op      (dec_op),
        .dec_byte    (dec_byte),
        .dec_dst     (dec_dst),
        .dec_src     (dec_src),
        .dec_use_imm (dec_use_imm),
        .dec_imm     (dec_imm),
        .dec_write   (dec_write),
        .dec_flags_wr(dec_flags_wr),
        .dec_illegal (dec_illegal)
    );

    alu_execute alu_execute_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .dec_valid   (dec_valid),
        .dec_ready   (dec_ready),
        .dec_op      (dec_op),
        .dec_byte    (dec_byte),
        .dec_dst     (dec_dst),
        .dec_src     (dec_src),
        .dec_use_imm (dec_use_imm),
        .dec_imm     (dec_imm),
        .dec_write   (dec_write),
        .dec_flags_wr(dec_flags_wr),
        .dec_illegal (dec_illegal),
        .q_full      (q_full),
        .q_push      (q_push),
        .q_reg       (q_reg),
        .q_value     (q_value),
        .q_flags     (q_flags),
        .q_illegal   (q_illegal)
    );

    result_queue result_queue_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .q_push     (q_push),
        .q_reg      (q_reg),
        .q_value    (q_value),
        .q_flags    (q_flags),
        .q_illegal  (q_illegal),
        .q_full     (q_full),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_reg    (out_reg),
        .out_value  (out_value),
        .out_flags  (out_flags),
        .out_illegal(out_illegal)
    );

endmodule

//--- result_queue.sv
// Two-entry result FIFO feeding the output valid/ready channel.
// The producer must not push while q_full is high.
// A push into an empty queue is visible on the output after that edge.

`timescale 1ns/1ps

module result_queue (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                q_push,
    input  logic [x86_isa_pkg::reg_idx_w-1:0]   q_reg,
    input  logic [x86_exec_pkg::data_w-1:0]     q_value,
    input  logic [x86_exec_pkg::flags_w-1:0]    q_flags,
    input  logic                                q_illegal,
    output logic                                q_full,
    output logic                                out_valid,
    input  logic                                out_ready,
    output logic [x86_isa_pkg::reg_idx_w-1:0]   out_reg,
    output logic [x86_exec_pkg::data_w-1:0]     out_value,
    output logic [x86_exec_pkg::flags_w-1:0]    out_flags,
    output logic                                out_illegal
);
    import x86_isa_pkg::*;
    import x86_exec_pkg::*;

    logic [reg_idx_w-1:0] reg_mem     [2];
    logic [data_w-1:0]    value_mem   [2];
    logic [flags_w-1:0]   flags_mem   [2];
    logic [1:0]           illegal_mem;
    logic                 wr_ptr;
    logic                 rd_ptr;
    logic [1:0]           count;
    logic                 pop;

    assign out_valid = count != 2'd0;
    assign q_full    = count == 2'd2;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            wr_ptr <= wr_ptr ^ q_push;
            rd_ptr <= rd_ptr ^ pop;
            count  <= count + {1'b0, q_push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (q_push) begin
            reg_mem[wr_ptr]     <= q_reg;
            value_mem[wr_ptr]   <= q_value;
            flags_mem[wr_ptr]   <= q_flags;
            illegal_mem[wr_ptr] <= q_illegal;
        end
    end

    // Head entry
    assign out_reg     = reg_mem[rd_ptr];
    assign out_value   = value_mem[rd_ptr];
    assign out_flags   = flags_mem[rd_ptr];
    assign out_illegal = illegal_mem[rd_ptr];

endmodule

//--- alu_execute.sv
// Combinational execute stage with register file and flags register.
// Writes back, updates flags and pushes a result at the transfer edge.
// dec_ready is simply the result queue's not-full.

`timescale 1ns/1ps

module alu_execute (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                dec_valid,
    output logic                                dec_ready,
    input  logic [x86_exec_pkg::alu_op_w-1:0]   dec_op,
    input  logic                                dec_byte,
    input  logic [x86_isa_pkg::reg_idx_w-1:0]   dec_dst,
    input  logic [x86_isa_pkg::reg_idx_w-1:0]   dec_src,
    input  logic                                dec_use_imm,
    input  logic [7:0]                          dec_imm,
    input  logic                                dec_write,
    input  logic                                dec_flags_wr,
    input  logic                                dec_illegal,
    input  logic                                q_full,
    output logic                                q_push,
    output logic [x86_isa_pkg::reg_idx_w-1:0]   q_reg,
    output logic [x86_exec_pkg::data_w-1:0]     q_value,
    output logic [x86_exec_pkg::flags_w-1:0]    q_flags,
    output logic                                q_illegal
);
    import x86_exec_pkg::*;

    logic                xfer;
    logic [data_w-1:0]   a_val;
    logic [data_w-1:0]   rb_val;
    logic [data_w-1:0]   b_val;
    logic [data_w:0]     sum;
    logic [data_w:0]     diff;
    logic [data_w-1:0]   raw;
    logic [data_w-1:0]   value;
    logic                carry;
    logic                ovf;
    logic                a_msb;
    logic                b_msb;
    logic                r_msb;
    logic [flags_w-1:0]  flags_q;
    logic [flags_w-1:0]  flags_nx;

    assign dec_ready = !q_full;
    assign xfer      = dec_valid && dec_ready;

    register_file register_file_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .byte_mode(dec_byte),
        .rd_a_sel (dec_dst),
        .rd_b_sel (dec_src),
        .rd_a_val (a_val),
        .rd_b_val (rb_val),
        .wr_sel   (dec_dst),
        .wr_val   (value),
        .wr_en    (xfer && dec_write)
    );

    assign b_val = dec_use_imm ? {8'h00, dec_imm} : rb_val;

    // Byte operands are zero-extended, so bit 8 is the byte carry or borrow
    assign sum  = {1'b0, a_val} + {1'b0, b_val};
    assign diff = {1'b0, a_val} - {1'b0, b_val};

    always_comb begin
        raw   = '0;
        carry = 1'b0;
        case (dec_op)
            alu_add: begin
                raw   = sum[data_w-1:0];
                carry = dec_byte ? sum[8] : sum[data_w];
            end
            alu_sub: begin
                raw   = diff[data_w-1:0];
                carry = dec_byte ? diff[8] : diff[data_w];
            end
            alu_or:   raw = a_val | b_val;
            alu_and:  raw = a_val & b_val;
            alu_xor:  raw = a_val ^ b_val;
            alu_pass: raw = b_val;
            default:  raw = '0;
        endcase
    end

    assign value = dec_byte ? {8'h00, raw[7:0]} : raw;
    assign a_msb = dec_byte ? a_val[7] : a_val[data_w-1];
    assign b_msb = dec_byte ? b_val[7] : b_val[data_w-1];
    assign r_msb = dec_byte ? value[7] : value[data_w-1];

    assign ovf = (dec_op == alu_add) ? (a_msb == b_msb) && (r_msb != a_msb) :
                 (dec_op == alu_sub) ? (a_msb != b_msb) && (r_msb != a_msb) : 1'b0;

    always_comb begin
        flags_nx         = '0;
        flags_nx[cf_idx] = carry;
        flags_nx[pf_idx] = ~^value[7:0];
        flags_nx[zf_idx] = value == '0;
        flags_nx[sf_idx] = r_msb;
        flags_nx[of_idx] = ovf;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags_q <= '0;
        end else if (xfer && dec_flags_wr) begin
            flags_q <= flags_nx;
        end
    end

    assign q_push    = xfer;
    assign q_reg     = dec_dst;
    assign q_value   = dec_illegal ? '0 : value;
    assign q_flags   = dec_flags_wr ? flags_nx : flags_q;
    assign q_illegal = dec_illegal;

endmodule

//--- register_file.sv
// Eight 16-bit general registers with two read ports and one write port.
// In byte mode, numbers 4..7 select the high byte of registers 0..3.
// Byte reads come back zero-extended; byte writes touch one lane only.

`timescale 1ns/1ps

module register_file (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                byte_mode,
    input  logic [x86_isa_pkg::reg_idx_w-1:0]   rd_a_sel,
    input  logic [x86_isa_pkg::reg_idx_w-1:0]   rd_b_sel,
    output logic [x86_exec_pkg::data_w-1:0]     rd_a_val,
    output logic [x86_exec_pkg::data_w-1:0]     rd_b_val,
    input  logic [x86_isa_pkg::reg_idx_w-1:0]   wr_sel,
    input  logic [x86_exec_pkg::data_w-1:0]     wr_val,
    input  logic                                wr_en
);
    import x86_isa_pkg::*;
    import x86_exec_pkg::*;

    logic [data_w-1:0] regs [1 << reg_idx_w];

    function automatic logic [data_w-1:0] lane_read(input logic [reg_idx_w-1:0] sel);
        logic [data_w-1:0] word;
        word = regs[sel[1:0]];
        if (!byte_mode) begin
            return regs[sel];
        end
        return sel[2] ? {8'h00, word[15:8]} : {8'h00, word[7:0]};
    endfunction

    always_comb begin
        rd_a_val = lane_read(rd_a_sel);
        rd_b_val = lane_read(rd_b_sel);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < (1 << reg_idx_w); i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            if (!byte_mode) begin
                regs[wr_sel] <= wr_val;
            end else if (wr_sel[2]) begin
                regs[wr_sel[1:0]][15:8] <= wr_val[7:0];
            end else begin
                regs[wr_sel[1:0]][7:0] <= wr_val[7:0];
            end
        end
    end

endmodule

//--- insn_decode.sv
// Single register stage between the instruction channel and execute.
// in_insn must be held while in_valid is high and in_ready is low.
// All legality checks live here; illegal items carry dst 0 and no writes.

`timescale 1ns/1ps

module insn_decode (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                in_valid,
    input  logic [x86_isa_pkg::insn_w-1:0]      in_insn,
    output logic                                in_ready,
    output logic                                dec_valid,
    input  logic                                dec_ready,
    output logic [x86_exec_pkg::alu_op_w-1:0]   dec_op,
    output logic                                dec_byte,
    output logic [x86_isa_pkg::reg_idx_w-1:0]   dec_dst,
    output logic [x86_isa_pkg::reg_idx_w-1:0]   dec_src,
    output logic                                dec_use_imm,
    output logic [7:0]                          dec_imm,
    output logic                                dec_write,
    output logic                                dec_flags_wr,
    output logic                                dec_illegal
);
    import x86_isa_pkg::*;
    import x86_exec_pkg::*;

    logic [7:0]          opcode;
    operand_byte_t       operand;
    logic [alu_op_w-1:0] nx_op;
    logic                nx_alu;
    logic                nx_mov;
    logic                nx_cmp;
    logic                nx_legal;

    assign opcode  = in_insn[insn_w-1:8];
    assign operand = in_insn[7:0];

    // Stage can take a new word when empty or draining this cycle
    assign in_ready = !dec_valid || dec_ready;

    always_comb begin
        nx_alu = 1'b1;
        nx_op  = alu_add;
        case (opcode)
            op_add8, op_add16: nx_op = alu_add;
            op_or8, op_or16:   nx_op = alu_or;
            op_and8, op_and16: nx_op = alu_and;
            op_sub8, op_sub16: nx_op = alu_sub;
            op_xor8, op_xor16: nx_op = alu_xor;
            // CMP is a subtract without write back
            op_cmp8, op_cmp16: nx_op = alu_sub;
            default:           nx_alu = 1'b0;
        endcase
    end

    assign nx_mov   = opcode[7:3] == op_mov_imm8_base[7:3];
    assign nx_cmp   = opcode == op_cmp8 || opcode == op_cmp16;
    assign nx_legal = nx_mov || (nx_alu && operand.modrm.mod == mod_reg);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else if (in_ready) begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            dec_op       <= nx_mov ? alu_pass : nx_op;
            dec_byte     <= nx_mov || !opcode[0];
            dec_dst      <= !nx_legal ? '0 : (nx_mov ? opcode[2:0] : operand.modrm.rm);
            dec_src      <= operand.modrm.reg_op;
            dec_use_imm  <= nx_mov;
            dec_imm      <= operand.imm8;
            dec_write    <= nx_legal && !nx_cmp;
            dec_flags_wr <= nx_legal && !nx_mov;
            dec_illegal  <= !nx_legal;
        end
    end

endmodule

//--- x86_exec_pkg.sv
// Execution side definitions: datapath width, ALU codes and flag layout.
// The flags vector holds only CF, PF, ZF, SF and OF, packed from bit 0.

package x86_exec_pkg;

    localparam int data_w   = 16;
    localparam int alu_op_w = 3;
    localparam int flags_w  = 5;

    localparam logic [2:0] alu_add  = 3'd0;
    localparam logic [2:0] alu_or   = 3'd1;
    localparam logic [2:0] alu_and  = 3'd2;
    localparam logic [2:0] alu_sub  = 3'd3;
    localparam logic [2:0] alu_xor  = 3'd4;
    // Forwards operand b, used by MOV
    localparam logic [2:0] alu_pass = 3'd5;

    localparam int cf_idx = 0;
    localparam int pf_idx = 1;
    localparam int zf_idx = 2;
    localparam int sf_idx = 3;
    localparam int of_idx = 4;

endpackage

//--- x86_isa_pkg.sv
// Instruction encoding for the register-form ALU subset of the 16-bit x86.
// One instruction is one 16-bit word: opcode in the high byte, ModRM or
// imm8 in the low byte. Only mod == 3 register operands are legal.
// The ModRM reg field is named reg_op because reg is a keyword.

package x86_isa_pkg;

    localparam int insn_w    = 16;
    localparam int reg_idx_w = 3;

    // Register forms, low bit selects 16-bit width
    localparam logic [7:0] op_add8  = 8'h00;
    localparam logic [7:0] op_add16 = 8'h01;
    localparam logic [7:0] op_or8   = 8'h08;
    localparam logic [7:0] op_or16  = 8'h09;
    localparam logic [7:0] op_and8  = 8'h20;
    localparam logic [7:0] op_and16 = 8'h21;
    localparam logic [7:0] op_sub8  = 8'h28;
    localparam logic [7:0] op_sub16 = 8'h29;
    localparam logic [7:0] op_xor8  = 8'h30;
    localparam logic [7:0] op_xor16 = 8'h31;
    localparam logic [7:0] op_cmp8  = 8'h38;
    localparam logic [7:0] op_cmp16 = 8'h39;

    // MOV r8, imm8 spans B0..B7, register in the low 3 bits
    localparam logic [7:0] op_mov_imm8_base = 8'hb0;

    localparam logic [1:0] mod_reg = 2'b11;

    typedef struct packed {
        logic [1:0] mod;
        logic [2:0] reg_op;
        logic [2:0] rm;
    } modrm_t;

    // Low byte of the instruction word, decoded by opcode
    typedef union packed {
        modrm_t     modrm;
        logic [7:0] imm8;
    } operand_byte_t;

    // 16-bit register numbers
    localparam logic [2:0] reg_ax = 3'd0;
    localparam logic [2:0] reg_cx = 3'd1;
    localparam logic [2:0] reg_dx = 3'd2;
    localparam logic [2:0] reg_bx = 3'd3;
    localparam logic [2:0] reg_sp = 3'd4;
    localparam logic [2:0] reg_bp = 3'd5;
    localparam logic [2:0] reg_si = 3'd6;
    localparam logic [2:0] reg_di = 3'd7;

    // 8-bit numbers, 4..7 are the high bytes of registers 0..3
    localparam logic [2:0] reg_al = 3'd0;
    localparam logic [2:0] reg_cl = 3'd1;
    localparam logic [2:0] reg_dl = 3'd2;
    localparam logic [2:0] reg_bl = 3'd3;
    localparam logic [2:0] reg_ah = 3'd4;
    localparam logic [2:0] reg_ch = 3'd5;
    localparam logic [2:0] reg_dh = 3'd6;
    localparam logic [2:0] reg_bh = 3'd7;

endpackage
